// File: dv/soc_tb.sv
module soc_tb
  import soc_pkg::*;
();
  logic        clk;
  logic        rst;
  logic        imem_valid;
  logic [31:0] imem_addr;
  logic [31:0] imem_wdata;
  logic [3:0]  imem_wstrb;
  logic        dmem_valid;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        imem_ready;
  logic [31:0] imem_rdata;
  logic        dmem_ready;
  logic [31:0] dmem_rdata;
  logic        tx;
  logic        msip;
  logic        mtip;
  logic [63:0] mtime;
  logic        imem_new; // High for the first cycle of a request.
  logic        dmem_new;
  logic [63:0] cmp_model;
  logic [63:0] clk_count; // Clocks since reset was released.
  logic [31:0] bram_model [bram_words];
  integer      seed;
  int          errors;
  int          tests;
  int          failed_tests;
  time         imem_done_t;
  time         dmem_done_t;

  soc dut_i (
    .clk(clk), .rst(rst),
    .imem_valid_i(imem_valid), .imem_addr_i(imem_addr),
    .imem_wdata_i(imem_wdata), .imem_wstrb_i(imem_wstrb),
    .dmem_valid_i(dmem_valid), .dmem_addr_i(dmem_addr),
    .dmem_wdata_i(dmem_wdata), .dmem_wstrb_i(dmem_wstrb),
    .rx_i(tx), // Serial loopback.
    .imem_ready_o(imem_ready), .imem_rdata_o(imem_rdata),
    .dmem_ready_o(dmem_ready), .dmem_rdata_o(dmem_rdata),
    .tx_o(tx), .msip_o(msip), .mtip_o(mtip), .mtime_o(mtime)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst) clk_count <= '0;
    else clk_count <= clk_count + 1;
  end

  dmem_next_a: assert property (@(posedge clk) disable iff (!rst) dmem_new |=> dmem_ready)
    else begin
      $display("data port ready did not follow its request by one cycle");
      errors = errors + 1;
    end
  imem_next_a: assert property (@(posedge clk) disable iff (!rst)
    imem_new && !dmem_new |=> imem_ready)
    else begin
      $display("instruction port ready did not follow its unstalled request by one cycle");
      errors = errors + 1;
    end
  dmem_only_a: assert property (@(posedge clk) disable iff (!rst) dmem_ready |-> dmem_valid)
    else begin
      $display("data port ready without a request");
      errors = errors + 1;
    end
  imem_only_a: assert property (@(posedge clk) disable iff (!rst) imem_ready |-> imem_valid)
    else begin
      $display("instruction port ready without a request");
      errors = errors + 1;
    end
  mtime_a: assert property (@(posedge clk) disable iff (!rst) mtime == clk_count / rtc_div)
    else begin
      $display("mismatch mtime: expected %0h, actual %0h", $sampled(clk_count) / rtc_div,
               $sampled(mtime));
      errors = errors + 1;
    end
  mtip_a: assert property (@(posedge clk) disable iff (!rst)
    mtip == (clk_count / rtc_div >= cmp_model))
    else begin
      $display("mismatch mtip: expected %0b, actual %0b",
               $sampled(clk_count) / rtc_div >= $sampled(cmp_model), $sampled(mtip));
      errors = errors + 1;
    end

  // Starts and returns one time unit after a rising edge.
  task automatic bus_access(input bit dport, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int   cycles;
    logic rdy;
    cycles = 0;
    rdy = 1'b0;
    if (dport) begin
      dmem_addr = addr;
      dmem_wdata = wdata;
      dmem_wstrb = wstrb;
      dmem_valid = 1'b1;
      dmem_new = 1'b1;
    end else begin
      imem_addr = addr;
      imem_wdata = wdata;
      imem_wstrb = wstrb;
      imem_valid = 1'b1;
      imem_new = 1'b1;
    end
    @(posedge clk);
    #1;
    if (dport) dmem_new = 1'b0;
    else imem_new = 1'b0;
    while (cycles < 32) begin
      @(negedge clk);
      rdy = dport ? dmem_ready : imem_ready;
      if (rdy) break;
      cycles++;
      @(posedge clk);
      #1;
    end
    if (!rdy) begin
      $display("%s port got no ready for address %h", dport ? "data" : "instruction", addr);
      errors = errors + 1;
    end
    // Mirror of mtimecmp updated in the cycle the CLINT takes the write.
    if (rdy && |wstrb && addr == clint_base_addr + clint_cmp_lo_off) cmp_model[31:0] = wdata;
    if (rdy && |wstrb && addr == clint_base_addr + clint_cmp_hi_off) cmp_model[63:32] = wdata;
    rdata = dport ? dmem_rdata : imem_rdata;
    if (dport) dmem_done_t = $time;
    else imem_done_t = $time;
    @(posedge clk);
    #1;
    if (dport) dmem_valid = 1'b0;
    else imem_valid = 1'b0;
  endtask

  task automatic expect_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors != err_before) begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] rd2;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] t0;
    logic [3:0]  strb;
    int          e;
    int          cnt;
    rst = 1'b0;
    imem_valid = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    imem_wstrb = '0;
    dmem_valid = 1'b0;
    dmem_addr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    imem_new = 1'b0;
    dmem_new = 1'b0;
    cmp_model = '1;
    seed = 32'h2dad;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b1;

    e = errors;
    for (int i = 0; i < 8; i++) begin
      addr = bram_base_addr + 32'(i * 132);
      data = $random(seed);
      bus_access(1'b1, addr, data, 4'hf, rd);
      bram_model[addr[9:2]] = data;
      data = $random(seed);
      strb = 4'(i + 1); // Assorted byte lanes.
      bus_access(1'b1, addr, data, strb, rd);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) bram_model[addr[9:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
    for (int i = 0; i < 8; i++) begin
      addr = bram_base_addr + 32'(i * 132);
      bus_access(1'b1, addr, '0, 4'h0, rd);
      expect_equal("bram", bram_model[addr[9:2]], rd);
      bus_access(1'b0, addr, '0, 4'h0, rd);
      expect_equal("bram", bram_model[addr[9:2]], rd);
    end
    finish_test("bram", e);

    e = errors;
    data = $random(seed);
    addr = bram_base_addr + 32'd132;
    fork
      bus_access(1'b1, addr, data, 4'hf, rd);
      bus_access(1'b0, addr, '0, 4'h0, rd2);
    join
    bram_model[addr[9:2]] = data;
    expect_equal("conflict", data, rd2); // Data port write lands before the fetch.
    fork
      bus_access(1'b1, bram_base_addr, '0, 4'h0, rd);
      bus_access(1'b0, bram_base_addr + 32'd264, '0, 4'h0, rd2);
    join
    expect_equal("conflict", bram_model[0], rd);
    expect_equal("conflict", bram_model[66], rd2);
    assert (dmem_done_t < imem_done_t) else begin
      $display("conflict: the data port was not served first");
      errors = errors + 1;
    end
    finish_test("conflict", e);

    e = errors;
    bus_access(1'b1, 32'h3000_0000, '0, 4'h0, rd);
    expect_equal("unmapped", 0, rd);
    bus_access(1'b0, uart_top_addr, '0, 4'h0, rd);
    expect_equal("unmapped", 0, rd);
    bus_access(1'b1, 32'hffff_fffc, 32'h1234_5678, 4'hf, rd);
    expect_equal("unmapped", 0, rd);
    finish_test("unmapped", e);

    e = errors;
    bus_access(1'b1, uart_base_addr + uart_txdata_off, 32'ha5, 4'h1, rd);
    bus_access(1'b1, uart_base_addr + uart_status_off, '0, 4'h0, rd);
    expect_equal("uart", 1, rd[0]); // Transmitter busy.
    cnt = 0;
    while (!rd[1] && cnt < 200) begin
      bus_access(1'b1, uart_base_addr + uart_status_off, '0, 4'h0, rd);
      cnt++;
    end
    if (!rd[1]) begin
      $display("uart: the looped back byte never set rx full");
      errors = errors + 1;
    end
    bus_access(1'b1, uart_base_addr + uart_rxdata_off, '0, 4'h0, rd);
    expect_equal("uart", 32'ha5, rd);
    bus_access(1'b1, uart_base_addr + uart_status_off, '0, 4'h0, rd);
    expect_equal("uart", 0, rd[1]);
    finish_test("uart", e);

    e = errors;
    bus_access(1'b1, clint_base_addr + clint_msip_off, 32'h1, 4'hf, rd);
    expect_equal("msip", 1, msip);
    bus_access(1'b1, clint_base_addr + clint_msip_off, '0, 4'h0, rd);
    expect_equal("msip", 1, rd);
    bus_access(1'b1, clint_base_addr + clint_msip_off, 32'h0, 4'hf, rd);
    expect_equal("msip", 0, msip);
    finish_test("msip", e);

    e = errors;
    bus_access(1'b1, clint_base_addr + clint_time_lo_off, '0, 4'h0, t0);
    repeat (2 * rtc_div) @(posedge clk);
    #1;
    bus_access(1'b1, clint_base_addr + clint_time_lo_off, '0, 4'h0, rd);
    assert (rd > t0) else begin
      $display("timer: mtime did not increase between two reads");
      errors = errors + 1;
    end
    bus_access(1'b1, clint_base_addr + clint_time_hi_off, '0, 4'h0, rd2);
    bus_access(1'b1, clint_base_addr + clint_cmp_lo_off, rd + 32'd10, 4'hf, data);
    bus_access(1'b1, clint_base_addr + clint_cmp_hi_off, rd2, 4'hf, data);
    expect_equal("timer", 0, mtip);
    cnt = 0;
    while (!mtip && cnt < 200) begin
      @(negedge clk);
      cnt++;
    end
    if (!mtip) begin
      $display("timer: mtip_o never rose after mtimecmp was reached");
      errors = errors + 1;
    end
    @(posedge clk);
    #1;
    bus_access(1'b1, clint_base_addr + clint_cmp_hi_off, 32'hffff_ffff, 4'hf, rd);
    expect_equal("timer", 0, mtip);
    finish_test("timer", e);

    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
source/soc_pkg.sv
source/bus_decoder.sv
source/response_router.sv
source/bram.sv
source/uart.sv
source/clint.sv
source/soc.sv
dv/soc_tb.sv

// File: source/bram.sv
module bram
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic        ready_o,
  output logic [31:0] rdata_o
);
  logic [31:0] mem [bram_words];
  logic [$clog2(bram_words)-1:0] idx;
  logic [31:0] merged;

  assign idx = addr_i[$clog2(bram_words)+1:2]; // Word index.

  always_comb begin
    merged = mem[idx];
    for (int b = 0; b < 4; b++) begin
      if (wstrb_i[b]) merged[8*b +: 8] = wdata_i[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      if (|wstrb_i) mem[idx] <= merged;
      rdata_o <= merged; // Read returns the word after the write.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= valid_i;
    end
  end

endmodule

// File: source/bus_decoder.sv
module bus_decoder
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  input  logic        dmem_valid_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  input  logic        imem_pend_i,
  input  logic        dmem_pend_i,
  output logic        bram_valid_o,
  output logic [31:0] bram_addr_o,
  output logic [31:0] bram_wdata_o,
  output logic [3:0]  bram_wstrb_o,
  output logic        uart_valid_o,
  output logic [31:0] uart_addr_o,
  output logic [31:0] uart_wdata_o,
  output logic [3:0]  uart_wstrb_o,
  output logic        clint_valid_o,
  output logic [31:0] clint_addr_o,
  output logic [31:0] clint_wdata_o,
  output logic [3:0]  clint_wstrb_o,
  output logic        imem_fwd_o,
  output target_e     imem_tgt_o,
  output logic        dmem_fwd_o,
  output target_e     dmem_tgt_o
);
  logic [2:0] d_sel;
  logic [2:0] i_sel;

  function automatic target_e decode(logic [31:0] addr);
    target_e t;
    if (addr >= bram_base_addr && addr < bram_top_addr) t = tgt_bram;
    else if (addr >= uart_base_addr && addr < uart_top_addr) t = tgt_uart;
    else if (addr >= clint_base_addr && addr < clint_top_addr) t = tgt_clint;
    else t = tgt_none;
    return t;
  endfunction

  assign imem_tgt_o = decode(imem_addr_i);
  assign dmem_tgt_o = decode(dmem_addr_i);

  // Data port has priority on a shared target.
  assign dmem_fwd_o = dmem_valid_i && !dmem_pend_i;
  assign imem_fwd_o = imem_valid_i && !imem_pend_i &&
                      !(dmem_fwd_o && imem_tgt_o == dmem_tgt_o && imem_tgt_o != tgt_none);

  always_comb begin
    for (int t = 0; t < 3; t++) begin
      d_sel[t] = dmem_fwd_o && dmem_tgt_o == target_e'(t);
      i_sel[t] = imem_fwd_o && imem_tgt_o == target_e'(t);
    end
  end

  assign bram_valid_o = d_sel[tgt_bram] | i_sel[tgt_bram];
  assign bram_addr_o = d_sel[tgt_bram] ? dmem_addr_i - bram_base_addr
                                       : imem_addr_i - bram_base_addr;
  assign bram_wdata_o = d_sel[tgt_bram] ? dmem_wdata_i : imem_wdata_i;
  assign bram_wstrb_o = d_sel[tgt_bram] ? dmem_wstrb_i : imem_wstrb_i;

  assign uart_valid_o = d_sel[tgt_uart] | i_sel[tgt_uart];
  assign uart_addr_o = d_sel[tgt_uart] ? dmem_addr_i - uart_base_addr
                                       : imem_addr_i - uart_base_addr;
  assign uart_wdata_o = d_sel[tgt_uart] ? dmem_wdata_i : imem_wdata_i;
  assign uart_wstrb_o = d_sel[tgt_uart] ? dmem_wstrb_i : imem_wstrb_i;

  assign clint_valid_o = d_sel[tgt_clint] | i_sel[tgt_clint];
  assign clint_addr_o = d_sel[tgt_clint] ? dmem_addr_i - clint_base_addr
                                         : imem_addr_i - clint_base_addr;
  assign clint_wdata_o = d_sel[tgt_clint] ? dmem_wdata_i : imem_wdata_i;
  assign clint_wstrb_o = d_sel[tgt_clint] ? dmem_wstrb_i : imem_wstrb_i;

  // A held request must not reach a target twice while its response is due.
  imem_once_a: assert property (@(posedge clk) disable iff (!rst) imem_fwd_o |=> !imem_fwd_o);
  dmem_once_a: assert property (@(posedge clk) disable iff (!rst) dmem_fwd_o |=> !dmem_fwd_o);

endmodule

// File: source/clint.sv
module clint
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic        ready_o,
  output logic [31:0] rdata_o,
  output logic        msip_o,
  output logic        mtip_o,
  output logic [63:0] mtime_o
);
  logic [31:0] pre_cnt;
  logic [63:0] mtimecmp;
  logic        tick;
  logic        wr;

  assign tick = pre_cnt == rtc_div - 1;
  assign wr = valid_i && |wstrb_i;

  always_ff @(posedge clk) begin
    if (!rst) begin
      pre_cnt <= '0;
      mtime_o <= '0;
      mtimecmp <= '1; // No timer interrupt until programmed.
      msip_o <= 1'b0;
      ready_o <= 1'b0;
    end else begin
      ready_o <= valid_i;
      pre_cnt <= tick ? '0 : pre_cnt + 1;
      if (tick) mtime_o <= mtime_o + 1;
      // Register writes win over the tick.
      if (wr) begin
        case (addr_i)
          clint_msip_off: msip_o <= wdata_i[0];
          clint_cmp_lo_off: mtimecmp[31:0] <= wdata_i;
          clint_cmp_hi_off: mtimecmp[63:32] <= wdata_i;
          clint_time_lo_off: mtime_o[31:0] <= wdata_i;
          clint_time_hi_off: mtime_o[63:32] <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      case (addr_i)
        clint_msip_off: rdata_o <= {31'b0, msip_o};
        clint_cmp_lo_off: rdata_o <= mtimecmp[31:0];
        clint_cmp_hi_off: rdata_o <= mtimecmp[63:32];
        clint_time_lo_off: rdata_o <= mtime_o[31:0];
        clint_time_hi_off: rdata_o <= mtime_o[63:32];
        default: rdata_o <= '0;
      endcase
    end
  end

  assign mtip_o = mtime_o >= mtimecmp;

endmodule

// File: source/response_router.sv
module response_router
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_fwd_i,
  input  target_e     imem_tgt_i,
  input  logic        dmem_fwd_i,
  input  target_e     dmem_tgt_i,
  input  logic        bram_ready_i,
  input  logic [31:0] bram_rdata_i,
  input  logic        uart_ready_i,
  input  logic [31:0] uart_rdata_i,
  input  logic        clint_ready_i,
  input  logic [31:0] clint_rdata_i,
  output logic        imem_ready_o,
  output logic [31:0] imem_rdata_o,
  output logic        dmem_ready_o,
  output logic [31:0] dmem_rdata_o,
  output logic        imem_pend_o,
  output logic        dmem_pend_o
);
  target_e     imem_tgt_q;
  target_e     dmem_tgt_q;
  logic [3:0]  tgt_ready;
  logic [31:0] tgt_rdata [4];

  // Unmapped requests answer by themselves with zero data.
  assign tgt_ready = {1'b1, clint_ready_i, uart_ready_i, bram_ready_i};
  assign tgt_rdata[tgt_bram] = bram_rdata_i;
  assign tgt_rdata[tgt_uart] = uart_rdata_i;
  assign tgt_rdata[tgt_clint] = clint_rdata_i;
  assign tgt_rdata[tgt_none] = '0;

  always_ff @(posedge clk) begin
    if (!rst) begin
      imem_pend_o <= 1'b0;
      dmem_pend_o <= 1'b0;
      imem_tgt_q <= tgt_none;
      dmem_tgt_q <= tgt_none;
    end else begin
      if (imem_fwd_i) begin
        imem_pend_o <= 1'b1;
        imem_tgt_q <= imem_tgt_i;
      end else if (imem_ready_o) imem_pend_o <= 1'b0;
      if (dmem_fwd_i) begin
        dmem_pend_o <= 1'b1;
        dmem_tgt_q <= dmem_tgt_i;
      end else if (dmem_ready_o) dmem_pend_o <= 1'b0;
    end
  end

  assign imem_ready_o = imem_pend_o & tgt_ready[imem_tgt_q];
  assign imem_rdata_o = tgt_rdata[imem_tgt_q];
  assign dmem_ready_o = dmem_pend_o & tgt_ready[dmem_tgt_q];
  assign dmem_rdata_o = tgt_rdata[dmem_tgt_q];

  // Targets answer exactly one cycle after a forward, and never otherwise.
  imem_resp_a: assert property (@(posedge clk) disable iff (!rst)
    imem_ready_o == $past(imem_fwd_i));
  dmem_resp_a: assert property (@(posedge clk) disable iff (!rst)
    dmem_ready_o == $past(dmem_fwd_i));

endmodule

// File: source/soc.sv
module soc
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  input  logic        dmem_valid_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  input  logic        rx_i,
  output logic        imem_ready_o,
  output logic [31:0] imem_rdata_o,
  output logic        dmem_ready_o,
  output logic [31:0] dmem_rdata_o,
  output logic        tx_o,
  output logic        msip_o,
  output logic        mtip_o,
  output logic [63:0] mtime_o
);
  logic        bram_valid, uart_valid, clint_valid;
  logic [31:0] bram_addr, uart_addr, clint_addr;
  logic [31:0] bram_wdata, uart_wdata, clint_wdata;
  logic [3:0]  bram_wstrb, uart_wstrb, clint_wstrb;
  logic        bram_ready, uart_ready, clint_ready;
  logic [31:0] bram_rdata, uart_rdata, clint_rdata;
  logic        imem_fwd, dmem_fwd, imem_pend, dmem_pend;
  target_e     imem_tgt, dmem_tgt;

  bus_decoder u_dec (
    .*,
    .imem_pend_i(imem_pend), .dmem_pend_i(dmem_pend),
    .bram_valid_o(bram_valid), .bram_addr_o(bram_addr),
    .bram_wdata_o(bram_wdata), .bram_wstrb_o(bram_wstrb),
    .uart_valid_o(uart_valid), .uart_addr_o(uart_addr),
    .uart_wdata_o(uart_wdata), .uart_wstrb_o(uart_wstrb),
    .clint_valid_o(clint_valid), .clint_addr_o(clint_addr),
    .clint_wdata_o(clint_wdata), .clint_wstrb_o(clint_wstrb),
    .imem_fwd_o(imem_fwd), .imem_tgt_o(imem_tgt),
    .dmem_fwd_o(dmem_fwd), .dmem_tgt_o(dmem_tgt)
  );

  bram u_bram (
    .clk(clk), .rst(rst),
    .valid_i(bram_valid), .addr_i(bram_addr), .wdata_i(bram_wdata), .wstrb_i(bram_wstrb),
    .ready_o(bram_ready), .rdata_o(bram_rdata)
  );

  uart u_uart (
    .clk(clk), .rst(rst),
    .valid_i(uart_valid), .addr_i(uart_addr), .wdata_i(uart_wdata), .wstrb_i(uart_wstrb),
    .rx_i(rx_i), .ready_o(uart_ready), .rdata_o(uart_rdata), .tx_o(tx_o)
  );

  clint u_clint (
    .clk(clk), .rst(rst),
    .valid_i(clint_valid), .addr_i(clint_addr), .wdata_i(clint_wdata),
    .wstrb_i(clint_wstrb), .ready_o(clint_ready), .rdata_o(clint_rdata),
    .msip_o(msip_o), .mtip_o(mtip_o), .mtime_o(mtime_o)
  );

  response_router u_rtr (
    .*,
    .imem_fwd_i(imem_fwd), .imem_tgt_i(imem_tgt),
    .dmem_fwd_i(dmem_fwd), .dmem_tgt_i(dmem_tgt),
    .bram_ready_i(bram_ready), .bram_rdata_i(bram_rdata),
    .uart_ready_i(uart_ready), .uart_rdata_i(uart_rdata),
    .clint_ready_i(clint_ready), .clint_rdata_i(clint_rdata),
    .imem_pend_o(imem_pend), .dmem_pend_o(dmem_pend)
  );

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

  // Top addresses of the address map are exclusive.
  localparam logic [31:0] bram_base_addr = 32'h0000_0000;
  localparam logic [31:0] bram_top_addr = 32'h0000_0400;
  localparam logic [31:0] uart_base_addr = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr = 32'h1000_0010;
  localparam logic [31:0] clint_base_addr = 32'h2000_0000;
  localparam logic [31:0] clint_top_addr = 32'h2000_0020;

  typedef enum logic [1:0] {
    tgt_bram,
    tgt_uart,
    tgt_clint,
    tgt_none
  } target_e;

  localparam int bram_words = 256;

  localparam logic [31:0] uart_div = 32'd8; // Clocks per bit.
  localparam logic [31:0] uart_txdata_off = 32'h0;
  localparam logic [31:0] uart_status_off = 32'h4;
  localparam logic [31:0] uart_rxdata_off = 32'h8;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } uart_state_e;

  localparam logic [31:0] rtc_div = 32'd4; // Clocks per mtime tick.
  localparam logic [31:0] clint_msip_off = 32'h00;
  localparam logic [31:0] clint_cmp_lo_off = 32'h08;
  localparam logic [31:0] clint_cmp_hi_off = 32'h0C;
  localparam logic [31:0] clint_time_lo_off = 32'h10;
  localparam logic [31:0] clint_time_hi_off = 32'h14;

endpackage

// File: source/uart.sv
module uart
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  input  logic        rx_i,
  output logic        ready_o,
  output logic [31:0] rdata_o,
  output logic        tx_o
);
  uart_state_e tx_st;
  uart_state_e rx_st;
  logic [31:0] tx_cnt;
  logic [31:0] rx_cnt;
  logic [2:0]  tx_bit;
  logic [2:0]  rx_bit;
  logic [7:0]  tx_shift;
  logic [7:0]  rx_shift;
  logic [7:0]  rx_data;
  logic        rx_full;
  logic        tx_wr;
  logic        rx_rd;

  assign tx_wr = valid_i && |wstrb_i && addr_i == uart_txdata_off;
  assign rx_rd = valid_i && wstrb_i == 4'b0 && addr_i == uart_rxdata_off;

  always_ff @(posedge clk) begin
    if (!rst) begin
      tx_st <= st_idle;
      tx_o <= 1'b1;
      tx_cnt <= '0;
      tx_bit <= '0;
    end else begin
      tx_cnt <= (tx_cnt == uart_div - 1 || tx_st == st_idle) ? '0 : tx_cnt + 1;
      case (tx_st)
        st_idle: if (tx_wr) begin
          tx_shift <= wdata_i[7:0];
          tx_o <= 1'b0; // Start bit.
          tx_st <= st_start;
        end
        st_start: if (tx_cnt == uart_div - 1) begin
          tx_o <= tx_shift[0];
          tx_bit <= '0;
          tx_st <= st_data;
        end
        st_data: if (tx_cnt == uart_div - 1) begin
          tx_shift <= tx_shift >> 1;
          tx_bit <= tx_bit + 1;
          tx_o <= (tx_bit == 3'd7) ? 1'b1 : tx_shift[1];
          if (tx_bit == 3'd7) tx_st <= st_stop;
        end
        default: if (tx_cnt == uart_div - 1) tx_st <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      rx_st <= st_idle;
      rx_cnt <= '0;
      rx_bit <= '0;
      rx_full <= 1'b0;
    end else begin
      rx_cnt <= rx_cnt + 1;
      if (rx_rd) rx_full <= 1'b0;
      case (rx_st)
        st_idle: begin
          rx_cnt <= '0;
          if (!rx_i) rx_st <= st_start;
        end
        st_start: if (rx_cnt == uart_div / 2 - 1) begin // Middle of the start bit.
          rx_cnt <= '0;
          rx_bit <= '0;
          rx_st <= rx_i ? st_idle : st_data;
        end
        st_data: if (rx_cnt == uart_div - 1) begin
          rx_cnt <= '0;
          rx_shift <= {rx_i, rx_shift[7:1]};
          rx_bit <= rx_bit + 1;
          if (rx_bit == 3'd7) rx_st <= st_stop;
        end
        default: if (rx_cnt == uart_div - 1) begin
          rx_st <= st_idle;
          if (rx_i) begin
            rx_data <= rx_shift;
            rx_full <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      case (addr_i)
        uart_status_off: rdata_o <= {30'b0, rx_full, tx_st != st_idle};
        uart_rxdata_off: rdata_o <= {24'b0, rx_data};
        default: rdata_o <= '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) ready_o <= 1'b0;
    else ready_o <= valid_i;
  end

endmodule
